// ==== run.sh ====
#!/usr/bin/env bash
# builds the opl3 register path testbench with verilator and runs it
# exit status is 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --timescale 1ns/10ps \
        -f vlog.f --top-module tb_opl3_regs -Mdir obj_dir -o sim_tb_opl3_regs; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb_opl3_regs 2>&1); then
    echo "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi

echo "$sim_out"

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== src/afifo.sv ====
/*
 * afifo
 * dual clock fifo, binary pointers address the memory and
 * gray copies cross to the other side through two flops.
 * full and empty use the synchronized pointers so both are
 * conservative; read data is valid whenever empty is low
 */
`timescale 1ns/10ps

module afifo #(
    parameter int LGFIFO = 5,                      // log2 depth, at least 2
    parameter int WIDTH  = 10
) (
    // write side
    input  logic             i_wclk,
    input  logic             i_wr_reset,           // sync, active high, wclk domain
    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_wr_data,
    output logic             o_wr_full,
    // read side
    input  logic             i_rclk,
    input  logic             i_rd_reset,           // sync, active high, rclk domain
    input  logic             i_rd,
    output logic [WIDTH-1:0] o_rd_data,
    output logic             o_rd_empty
);
    localparam int DEPTH = 1 << LGFIFO;

    logic [WIDTH-1:0] mem [DEPTH];                 // storage, no reset

    logic [LGFIFO:0] wr_bin, wr_bin_next;          // extra msb tells wrap
    logic [LGFIFO:0] wr_gray, wr_gray_next;
    logic [LGFIFO:0] rd_bin, rd_bin_next;
    logic [LGFIFO:0] rd_gray, rd_gray_next;
    logic [LGFIFO:0] rd_gray_w1, rd_gray_w2;       // read ptr seen in wclk
    logic [LGFIFO:0] wr_gray_r1, wr_gray_r2;       // write ptr seen in rclk
    logic            wr_en, rd_en;

    // write side
    assign wr_en        = i_wr && !o_wr_full;      // writes while full are dropped
    assign wr_bin_next  = wr_bin + {{LGFIFO{1'b0}}, wr_en};
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

    always_ff @(posedge i_wclk) begin
        if (i_wr_reset) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_w1 <= rd_gray;                 // first sync stage
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    always_ff @(posedge i_wclk) begin
        if (wr_en) begin
            mem[wr_bin[LGFIFO-1:0]] <= i_wr_data;
        end
    end

    // full when write ptr is one lap ahead, top two gray bits inverted
    assign o_wr_full = (wr_gray == {~rd_gray_w2[LGFIFO:LGFIFO-1], rd_gray_w2[LGFIFO-2:0]});

    // read side
    assign rd_en        = i_rd && !o_rd_empty;
    assign rd_bin_next  = rd_bin + {{LGFIFO{1'b0}}, rd_en};
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    always_ff @(posedge i_rclk) begin
        if (i_rd_reset) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_r1 <= wr_gray;                 // first sync stage
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    assign o_rd_empty = (rd_gray == wr_gray_r2);   // pointers equal, nothing to read
    assign o_rd_data  = mem[rd_bin[LGFIFO-1:0]];   // head entry, show-ahead

endmodule

// ==== src/host_if.sv ====
/*
 * host_if
 * captures host bus writes on clk_host, crosses them to clk
 * through an async fifo and pairs address and data port writes
 * into single register write pulses. the status byte goes back
 * to clk_host through a two flop synchronizer
 */
`timescale 1ns/10ps

module host_if #(
    parameter int LGFIFO = 5
) (
    input  logic                 clk,              // synth clock
    input  logic                 reset,
    input  logic                 clk_host,
    input  logic                 i_host_reset,     // clk_host domain
    input  logic                 i_cs_n,
    input  logic                 i_rd_n,           // qualifies reads on the host side only
    input  logic                 i_wr_n,
    input  opl3_pkg::host_addr_t i_address,
    input  opl3_pkg::reg_data_t  i_din,
    output opl3_pkg::reg_data_t  o_dout,
    input  opl3_pkg::reg_data_t  i_status,         // clk domain
    output logic                 o_reg_wr_valid,
    output logic                 o_reg_wr_bank,
    output opl3_pkg::reg_addr_t  o_reg_wr_address,
    output opl3_pkg::reg_data_t  o_reg_wr_data
);
    import opl3_pkg::*;

    localparam int FIFO_WIDTH = $bits(host_addr_t) + REG_FILE_DATA_WIDTH;

    logic                  wr, wr_p1, wr_push;
    logic                  fifo_full, fifo_empty, fifo_pop;
    logic [FIFO_WIDTH-1:0] fifo_rd_data;
    host_addr_t            fifo_addr;
    reg_data_t             fifo_data;
    reg_data_t             status_s1;              // first sync stage

    // host side, take only the leading edge of a held write
    assign wr      = !i_cs_n && !i_wr_n;
    assign wr_push = wr && !wr_p1 && !fifo_full;   // full drops the write

    always_ff @(posedge clk_host) begin
        if (i_host_reset) begin
            wr_p1 <= 1'b0;
        end else begin
            wr_p1 <= wr;
        end
    end

    afifo #(
        .LGFIFO (LGFIFO),
        .WIDTH  (FIFO_WIDTH)                       // port address + data
    ) i_afifo (
        .i_wclk     (clk_host),
        .i_wr_reset (i_host_reset),
        .i_wr       (wr_push),
        .i_wr_data  ({i_address, i_din}),
        .o_wr_full  (fifo_full),
        .i_rclk     (clk),
        .i_rd_reset (reset),
        .i_rd       (fifo_pop),
        .o_rd_data  (fifo_rd_data),
        .o_rd_empty (fifo_empty)
    );

    // synth side, one entry per clk
    assign fifo_pop               = !fifo_empty;
    assign {fifo_addr, fifo_data} = fifo_rd_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_reg_wr_valid   <= 1'b0;
            o_reg_wr_bank    <= 1'b0;
            o_reg_wr_address <= '0;
        end else begin
            o_reg_wr_valid <= 1'b0;                // single cycle pulse
            if (fifo_pop) begin
                if (!fifo_addr[0]) begin           // address port, hold bank and index
                    o_reg_wr_bank    <= fifo_addr[1];
                    o_reg_wr_address <= fifo_data;
                end else begin                     // data port, emit the write
                    o_reg_wr_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop && fifo_addr[0]) begin
            o_reg_wr_data <= fifo_data;
        end
    end

    // status back to host, bits need not be coherent
    always_ff @(posedge clk_host) begin
        if (i_host_reset) begin
            status_s1 <= '0;
            o_dout    <= '0;
        end else begin
            status_s1 <= i_status;
            o_dout    <= status_s1;
        end
    end

endmodule

// ==== src/opl3_pkg.sv ====
/*
 * opl3 register path package
 * shared data width, register and host port types,
 * timer register indices and control/status bit positions
 */
package opl3_pkg;
    localparam int REG_FILE_DATA_WIDTH = 8;             // host bus and register byte

    typedef logic [REG_FILE_DATA_WIDTH-1:0] reg_data_t; // one register byte
    typedef logic [7:0] reg_addr_t;                     // register index within a bank
    typedef logic [1:0] host_addr_t;                    // bit 0 data port, bit 1 bank 1

    // timer registers, bank 0 only
    localparam reg_addr_t TIMER1_REG     = 8'h02;       // timer 1 preset
    localparam reg_addr_t TIMER2_REG     = 8'h03;       // timer 2 preset
    localparam reg_addr_t TIMER_CTRL_REG = 8'h04;       // start, mask, irq reset

    // control register bits
    localparam int CTRL_IRQ_RESET_BIT = 7;              // clears both flags, nothing else
    localparam int CTRL_MASK_T1_BIT   = 6;
    localparam int CTRL_MASK_T2_BIT   = 5;
    localparam int CTRL_START_T2_BIT  = 1;
    localparam int CTRL_START_T1_BIT  = 0;

    // status byte bits
    localparam int STATUS_IRQ_BIT = 7;                  // or of both flags
    localparam int STATUS_FT1_BIT = 6;
    localparam int STATUS_FT2_BIT = 5;
endpackage

// ==== src/opl3_regs_top.sv ====
/*
 * opl3_regs_top
 * host register path of the fm core, host bus in, register
 * write stream out, with the timers returning the status byte
 */
`timescale 1ns/10ps

module opl3_regs_top #(
    parameter int LGFIFO            = 5,           // fifo depth 2**LGFIFO
    parameter int TIMER_TICK_CYCLES = 288          // clk cycles per timer 1 tick
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clk_host,
    input  logic                 i_host_reset,
    input  logic                 i_cs_n,
    input  logic                 i_rd_n,
    input  logic                 i_wr_n,
    input  opl3_pkg::host_addr_t i_address,
    input  opl3_pkg::reg_data_t  i_din,
    output opl3_pkg::reg_data_t  o_dout,
    output logic                 o_reg_wr_valid,
    output logic                 o_reg_wr_bank,
    output opl3_pkg::reg_addr_t  o_reg_wr_address,
    output opl3_pkg::reg_data_t  o_reg_wr_data
);
    import opl3_pkg::*;

    reg_data_t status;                             // clk domain, from timers

    host_if #(
        .LGFIFO (LGFIFO)
    ) i_host_if (
        .clk              (clk),
        .reset            (reset),
        .clk_host         (clk_host),
        .i_host_reset     (i_host_reset),
        .i_cs_n           (i_cs_n),
        .i_rd_n           (i_rd_n),
        .i_wr_n           (i_wr_n),
        .i_address        (i_address),
        .i_din            (i_din),
        .o_dout           (o_dout),
        .i_status         (status),
        .o_reg_wr_valid   (o_reg_wr_valid),
        .o_reg_wr_bank    (o_reg_wr_bank),
        .o_reg_wr_address (o_reg_wr_address),
        .o_reg_wr_data    (o_reg_wr_data)
    );

    // timers watch the same write stream that leaves the block
    opl3_timers #(
        .TIMER_TICK_CYCLES (TIMER_TICK_CYCLES)
    ) i_opl3_timers (
        .clk              (clk),
        .reset            (reset),
        .i_reg_wr_valid   (o_reg_wr_valid),
        .i_reg_wr_bank    (o_reg_wr_bank),
        .i_reg_wr_address (o_reg_wr_address),
        .i_reg_wr_data    (o_reg_wr_data),
        .o_status         (status)
    );

endmodule

// ==== src/opl3_timers.sv ====
/*
 * opl3_timers
 * decodes the bank 0 timer registers from the write stream,
 * runs timer 1 off a shared prescaler and timer 2 off a further
 * divide by four, and keeps the overflow flags and status byte
 */
`timescale 1ns/10ps

module opl3_timers #(
    parameter int TIMER_TICK_CYCLES = 288          // clk cycles per timer 1 tick
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_reg_wr_valid,
    input  logic                i_reg_wr_bank,
    input  opl3_pkg::reg_addr_t i_reg_wr_address,
    input  opl3_pkg::reg_data_t i_reg_wr_data,
    output opl3_pkg::reg_data_t o_status
);
    import opl3_pkg::*;

    localparam int TICK_W = (TIMER_TICK_CYCLES > 1) ? $clog2(TIMER_TICK_CYCLES) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TIMER_TICK_CYCLES - 1);

    logic              bank0_wr, ctrl_wr, irq_clr, ctrl_set;
    logic [1:0]        preset_wr;                  // index 0 timer 1, 1 timer 2
    logic [1:0]        load;                       // start bit written as 1
    logic [1:0]        start, mask, flag;
    logic [1:0]        tick, ovf;
    reg_data_t         preset [2];
    reg_data_t         cnt [2];
    logic [TICK_W-1:0] tick_cnt;                   // shared prescaler
    logic [1:0]        div4;                       // timer 2 runs 4x slower
    reg_data_t         status_next;

    // register decode
    assign bank0_wr     = i_reg_wr_valid && !i_reg_wr_bank;
    assign preset_wr[0] = bank0_wr && (i_reg_wr_address == TIMER1_REG);
    assign preset_wr[1] = bank0_wr && (i_reg_wr_address == TIMER2_REG);
    assign ctrl_wr      = bank0_wr && (i_reg_wr_address == TIMER_CTRL_REG);
    assign irq_clr      = ctrl_wr && i_reg_wr_data[CTRL_IRQ_RESET_BIT];
    assign ctrl_set     = ctrl_wr && !i_reg_wr_data[CTRL_IRQ_RESET_BIT];
    assign load[0]      = ctrl_set && i_reg_wr_data[CTRL_START_T1_BIT];
    assign load[1]      = ctrl_set && i_reg_wr_data[CTRL_START_T2_BIT];

    // prescaler, restarted on a start so the first tick is a full period away
    assign tick[0] = (tick_cnt == TICK_LAST);
    assign tick[1] = tick[0] && (div4 == 2'd3);

    always_ff @(posedge clk) begin
        if (reset || |load) begin
            tick_cnt <= '0;
            div4     <= '0;
        end else if (tick[0]) begin
            tick_cnt <= '0;
            div4     <= div4 + 2'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // control and preset registers
    always_ff @(posedge clk) begin
        if (reset) begin
            start     <= '0;
            mask      <= '0;
            preset[0] <= '0;
            preset[1] <= '0;
        end else begin
            if (ctrl_set) begin                    // irq reset write leaves these alone
                start <= {i_reg_wr_data[CTRL_START_T2_BIT], i_reg_wr_data[CTRL_START_T1_BIT]};
                mask  <= {i_reg_wr_data[CTRL_MASK_T2_BIT], i_reg_wr_data[CTRL_MASK_T1_BIT]};
            end
            for (int t = 0; t < 2; t++) begin
                if (preset_wr[t]) begin
                    preset[t] <= i_reg_wr_data;
                end
            end
        end
    end

    // counters and flags
    always_comb begin
        for (int t = 0; t < 2; t++) begin
            ovf[t] = start[t] && tick[t] && (cnt[t] == 8'hff); // wraps past 255
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            flag   <= '0;
        end else begin
            for (int t = 0; t < 2; t++) begin
                if (load[t] || ovf[t]) begin
                    cnt[t] <= preset[t];           // reload on start and overflow
                end else if (start[t] && tick[t]) begin
                    cnt[t] <= cnt[t] + 8'd1;
                end
                if (irq_clr) begin
                    flag[t] <= 1'b0;
                end else if (ovf[t] && !mask[t]) begin
                    flag[t] <= 1'b1;               // masked overflow sets nothing
                end
            end
        end
    end

    // status byte
    always_comb begin
        status_next                 = '0;
        status_next[STATUS_IRQ_BIT] = |flag;
        status_next[STATUS_FT1_BIT] = flag[0];
        status_next[STATUS_FT2_BIT] = flag[1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_status <= '0;
        end else begin
            o_status <= status_next;
        end
    end

endmodule

// ==== verification/tb_opl3_regs.sv ====
/*
 * tb_opl3_regs
 * testbench for the opl3 host register path, random register writes
 * checked against a queue model of the write stream, timer flag timing,
 * masked timers, irq reset and the idle state after reset
 */
`timescale 1ns/10ps

module tb_opl3_regs;
    import opl3_pkg::*;

    logic        clk, clk_host, reset, i_host_reset;
    logic        i_cs_n, i_rd_n, i_wr_n;
    host_addr_t  i_address;
    reg_data_t   i_din, o_dout;
    logic        o_reg_wr_valid, o_reg_wr_bank;
    reg_addr_t   o_reg_wr_address;
    reg_data_t   o_reg_wr_data;

    logic [16:0] exp_q [$];                        // {bank, address, data}, push only
    logic [16:0] head;
    int          rd_idx = 0;                       // next expected entry, monitor side
    logic        cur_bank = 1'b0;                  // model of held bank and address
    reg_addr_t   cur_addr = '0;
    int unsigned clk_cycles = 0;
    int          err_count = 0, mon_err_count = 0, timeout_count = 0, pulse_count = 0;

    opl3_regs_top #(
        .LGFIFO            (5),
        .TIMER_TICK_CYCLES (8)
    ) i_opl3_regs_top (
        .clk              (clk),
        .reset            (reset),
        .clk_host         (clk_host),
        .i_host_reset     (i_host_reset),
        .i_cs_n           (i_cs_n),
        .i_rd_n           (i_rd_n),
        .i_wr_n           (i_wr_n),
        .i_address        (i_address),
        .i_din            (i_din),
        .o_dout           (o_dout),
        .o_reg_wr_valid   (o_reg_wr_valid),
        .o_reg_wr_bank    (o_reg_wr_bank),
        .o_reg_wr_address (o_reg_wr_address),
        .o_reg_wr_data    (o_reg_wr_data)
    );

    always #2 clk = ~clk;                          // 4 ns
    always #3 clk_host = ~clk_host;                // 6 ns, unrelated to clk

    always @(posedge clk) begin
        clk_cycles <= clk_cycles + 1;
    end

    // returns 1 on a mismatch
    function automatic int check_byte(input string name, input reg_data_t got,
                                      input reg_data_t exp);
        check_byte = 0;
        assert (got === exp) else begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            check_byte = 1;
        end
    endfunction

    // every pulse must match the oldest pending write
    always @(negedge clk) begin
        if (o_reg_wr_valid === 1'b1) begin
            pulse_count++;
            assert (exp_q.size() > rd_idx) else begin
                $display("unexpected register write pulse at %0t, none pending", $time);
                mon_err_count++;
            end
            if (exp_q.size() > rd_idx) begin
                head = exp_q[rd_idx];
                rd_idx++;
                mon_err_count += check_byte("o_reg_wr_bank", {7'b0, o_reg_wr_bank},
                                            {7'b0, head[16]});
                mon_err_count += check_byte("o_reg_wr_address", o_reg_wr_address, head[15:8]);
                mon_err_count += check_byte("o_reg_wr_data", o_reg_wr_data, head[7:0]);
            end
        end
    end

    // strobe held 1 to 4 host cycles, only one fifo entry expected
    task automatic host_write(input host_addr_t port, input reg_data_t data);
        int unsigned hold;
        hold = 1 + ($urandom % 4);
        @(negedge clk_host);
        i_cs_n    = 1'b0;
        i_wr_n    = 1'b0;
        i_address = port;
        i_din     = data;
        repeat (hold) @(negedge clk_host);
        i_cs_n = 1'b1;
        i_wr_n = 1'b1;
    endtask

    task automatic host_read(output reg_data_t value);
        int unsigned hold;
        hold = 1 + ($urandom % 4);
        @(negedge clk_host);
        i_cs_n    = 1'b0;
        i_rd_n    = 1'b0;
        i_address = 2'b00;
        repeat (hold) @(negedge clk_host);
        value  = o_dout;                           // stable between host edges
        i_cs_n = 1'b1;
        i_rd_n = 1'b1;
    endtask

    task automatic addr_write(input logic bank, input reg_addr_t addr);
        host_write({bank, 1'b0}, addr);
        cur_bank = bank;
        cur_addr = addr;
    endtask

    task automatic data_write(input reg_data_t data);
        exp_q.push_back({cur_bank, cur_addr, data}); // uses held bank and address
        host_write({cur_bank, 1'b1}, data);
    endtask

    task automatic timer_write(input reg_addr_t addr, input reg_data_t data);
        addr_write(1'b0, addr);
        data_write(data);
    endtask

    // poll the status byte until the masked bits match, bounded in clk cycles
    task automatic wait_status(input reg_data_t mask, input reg_data_t want,
                               input int unsigned start, input int unsigned limit,
                               output reg_data_t value);
        host_read(value);
        while (((value & mask) != want) && (clk_cycles - start < limit)) begin
            host_read(value);
        end
        if ((value & mask) != want) begin
            timeout_count++;
            $display("timed out at %0t waiting for status %h under mask %h, last read %h",
                     $time, want, mask, value);
        end
    endtask

    task automatic check_min_delay(input string name, input int unsigned start,
                                   input int unsigned lo);
        assert (clk_cycles - start >= lo) else begin
            err_count++;
            $display("%s flag showed after %0d clk cycles, sooner than the %0d allowed",
                     name, clk_cycles - start, lo);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > rd_idx && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > rd_idx) begin
            timeout_count++;
            $display("timed out at %0t, %0d register writes never came out",
                     $time, exp_q.size() - rd_idx);
        end
    endtask

    initial begin
        reg_data_t   v, exp_status;
        reg_addr_t   a;
        logic        b;
        int          p1, p2;
        int unsigned start, window;
        void'($urandom(32'h957));
        clk          = 1'b0;
        clk_host     = 1'b0;
        reset        = 1'b1;
        i_host_reset = 1'b1;
        i_cs_n       = 1'b1;
        i_rd_n       = 1'b1;
        i_wr_n       = 1'b1;
        i_address    = '0;
        i_din        = '0;
        fork
            begin
                repeat (10) @(negedge clk);
                reset = 1'b0;
            end
            begin
                repeat (10) @(negedge clk_host);
                i_host_reset = 1'b0;
            end
        join

        // idle after reset, monitor flags any pulse
        repeat (20) begin
            host_read(v);
            err_count += check_byte("o_dout", v, 8'h00);
        end

        // random address/data pairs, sometimes a second data write to the same register
        for (int i = 0; i < 40; i++) begin
            b = 1'($urandom);
            a = 8'($urandom);
            if (!b && a >= TIMER1_REG && a <= TIMER_CTRL_REG) begin
                a = a ^ 8'h80;                     // keep the timers out of it
            end
            addr_write(b, a);
            data_write(8'($urandom));
            if ($urandom % 4 == 0) begin
                data_write(8'($urandom));
            end
        end
        wait_drain(200);

        // timer 1 overflow, (256 - P) ticks of 8 clk
        exp_status = '0;
        p1 = 240 + int'($urandom % 16);
        timer_write(TIMER1_REG, 8'(p1));
        addr_write(1'b0, TIMER_CTRL_REG);
        start = clk_cycles;
        data_write(8'h01);
        wait_status(8'h40, 8'h40, start, (256 - p1) * 8 + 64, v);
        check_min_delay("timer 1", start, (256 - p1) * 8);
        exp_status[STATUS_FT1_BIT] = 1'b1;
        exp_status[STATUS_IRQ_BIT] = 1'b1;
        host_read(v);
        err_count += check_byte("o_dout", v, exp_status);

        // timer 2, 32 clk per tick, also stops timer 1
        p2 = 248 + int'($urandom % 8);
        timer_write(TIMER2_REG, 8'(p2));
        addr_write(1'b0, TIMER_CTRL_REG);
        start = clk_cycles;
        data_write(8'h02);
        wait_status(8'h20, 8'h20, start, (256 - p2) * 32 + 64, v);
        check_min_delay("timer 2", start, (256 - p2) * 32);
        exp_status[STATUS_FT2_BIT] = 1'b1;
        host_read(v);
        err_count += check_byte("o_dout", v, exp_status);

        // stopping keeps the flags, irq reset clears them all
        timer_write(TIMER_CTRL_REG, 8'h00);
        start = clk_cycles;
        while (clk_cycles - start < 64) begin      // long enough for the write to reach o_dout
            host_read(v);
            err_count += check_byte("o_dout", v, exp_status);
        end
        timer_write(TIMER_CTRL_REG, 8'h80);
        start = clk_cycles;
        wait_status(8'hff, 8'h00, start, 64, v);
        err_count += check_byte("o_dout", v, 8'h00);

        // both timers masked, nothing may show for two periods
        p1 = 240 + int'($urandom % 16);
        p2 = 248 + int'($urandom % 8);
        timer_write(TIMER1_REG, 8'(p1));
        timer_write(TIMER2_REG, 8'(p2));
        timer_write(TIMER_CTRL_REG, 8'h63);
        start  = clk_cycles;
        window = 2 * (256 - p2) * 32 + 2 * (256 - p1) * 8;
        while (clk_cycles - start < window) begin
            host_read(v);
            err_count += check_byte("o_dout", v, 8'h00);
        end
        timer_write(TIMER_CTRL_REG, 8'h00);

        wait_drain(200);
        repeat (20) @(negedge clk);
        assert (pulse_count == exp_q.size()) else begin
            err_count++;
            $display("Fail at %0t: pulse count got %0d expected %0d",
                     $time, pulse_count, exp_q.size());
        end
        $display("errors %0d (host side %0d, write stream %0d), timeouts %0d",
                 err_count + mon_err_count, err_count, mon_err_count, timeout_count);
        if (err_count + mon_err_count + timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/opl3_pkg.sv
src/afifo.sv
src/host_if.sv
src/opl3_timers.sv
src/opl3_regs_top.sv
verification/tb_opl3_regs.sv
